// ==== run_sim.sh ====
#!/bin/sh
# Build the PDP-8 core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_pdp8_core -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_pdp8_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
  exit 0
fi
exit 1

// ==== sources.f ====
src/pdp8_pkg.sv
src/pdp8_ifs.sv
src/panel_intake.sv
src/cpu_controller.sv
src/cpu_datapath.sv
src/core_memory.sv
src/run_report.sv
src/pdp8_core.sv
verification/tb_clock_gen.sv
verification/tb_pdp8_core.sv

// ==== src/core_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core memory: 4096 words, request/finished with wait states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module core_memory #(
  parameter int MEM_WAIT_CYCLES = 2
) (
  input  logic  clock,
  input  logic  resetN,
  mem_if.memory mem
);
  import pdp8_pkg::*;

  localparam int CNT_W = (MEM_WAIT_CYCLES > 0) ? $clog2(MEM_WAIT_CYCLES + 1) : 1;

  word_t            mem_array [MEM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic             pending;
  logic             access;

  assign pending = (mem.read_enable || mem.write_enable) && !mem.finished;
  assign access  = pending && (wait_cnt == CNT_W'(MEM_WAIT_CYCLES));

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      wait_cnt     <= '0;
      mem.finished <= 1'b0;
    end else begin
      mem.finished <= access;                           // One-cycle pulse
      if (access)
        wait_cnt <= '0;
      else if (pending)
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (access && mem.write_enable)
      mem_array[mem.addr] <= mem.wdata;
    else if (access)
      mem.rdata <= mem_array[mem.addr];
  end

  a_addr_stable: assert property (@(posedge clock) disable iff (!resetN)
    pending |=> $stable(mem.addr))
    else $error("Memory address changed during a pending request");

endmodule

`default_nettype wire

// ==== src/cpu_controller.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU controller: FSM for fetch, decode, EA, execute,
// deposit and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cpu_controller (
  input  logic           clock,
  input  logic           resetN,
  panel_if.controller    panel,
  cpu_ctrl_if.controller ctrl,
  mem_if.controller      mem,
  input  logic           report_busy,
  output logic           report_capture
);
  import pdp8_pkg::*;

  typedef enum logic [4:0] {
    S_IDLE, S_LD_PC, S_DEP_1, S_DEP_2,
    S_FETCH_1, S_FETCH_2, S_FETCH_3, S_DECODE,
    S_IND_1, S_IND_2, S_IND_3,
    S_AND_1, S_AND_2, S_AND_3,
    S_TAD_1, S_TAD_2, S_TAD_3,
    S_ISZ_1, S_ISZ_2, S_ISZ_3, S_ISZ_4, S_ISZ_5, S_ISZ_6,
    S_DCA_1, S_DCA_2, S_DCA_3,
    S_JMP_1, S_HALT_WAIT, S_HALT_CAP
  } state_t;

  state_t  state;
  state_t  next_state;
  state_t  exec_state;
  opcode_t opcode;
  logic    is_halt;
  logic    is_dropped;

  assign opcode     = opcode_t'(ctrl.ir[11:9]);
  assign is_halt    = (ctrl.ir == HALT_WORD);
  assign is_dropped = (opcode == OP_JMS) || (opcode == OP_IOT) || (opcode == OP_OPR);

  always_comb begin
    case (opcode)                                       // Entry state after EA is known
      OP_AND:  exec_state = S_AND_1;
      OP_TAD:  exec_state = S_TAD_1;
      OP_ISZ:  exec_state = S_ISZ_1;
      OP_DCA:  exec_state = S_DCA_1;
      default: exec_state = S_JMP_1;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      state <= S_IDLE;
    else
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE: begin
        if (panel.cmd_valid) begin
          case (panel.cmd_op)
            CMD_LOAD_PC: next_state = S_LD_PC;
            CMD_DEPOSIT: next_state = S_DEP_1;
            default:     next_state = S_FETCH_1;
          endcase
        end
      end
      S_LD_PC:   next_state = S_IDLE;
      S_DEP_1:   next_state = S_DEP_2;
      S_DEP_2:   next_state = mem.finished ? S_IDLE : S_DEP_2;
      S_FETCH_1: next_state = S_FETCH_2;
      S_FETCH_2: next_state = mem.finished ? S_FETCH_3 : S_FETCH_2;
      S_FETCH_3: next_state = S_DECODE;
      S_DECODE: begin
        if (is_halt)
          next_state = S_HALT_WAIT;
        else if (is_dropped)
          next_state = S_FETCH_1;                       // Treated as NOP
        else if (ctrl.ir[8])
          next_state = S_IND_1;
        else
          next_state = exec_state;
      end
      S_IND_1:     next_state = S_IND_2;
      S_IND_2:     next_state = mem.finished ? S_IND_3 : S_IND_2;
      S_IND_3:     next_state = exec_state;
      S_AND_1:     next_state = S_AND_2;
      S_AND_2:     next_state = mem.finished ? S_AND_3 : S_AND_2;
      S_TAD_1:     next_state = S_TAD_2;
      S_TAD_2:     next_state = mem.finished ? S_TAD_3 : S_TAD_2;
      S_ISZ_1:     next_state = S_ISZ_2;
      S_ISZ_2:     next_state = mem.finished ? S_ISZ_3 : S_ISZ_2;
      S_ISZ_3:     next_state = S_ISZ_4;
      S_ISZ_4:     next_state = S_ISZ_5;
      S_ISZ_5:     next_state = mem.finished ? S_ISZ_6 : S_ISZ_5;
      S_DCA_1:     next_state = S_DCA_2;
      S_DCA_2:     next_state = mem.finished ? S_DCA_3 : S_DCA_2;
      S_HALT_WAIT: next_state = report_busy ? S_HALT_WAIT : S_HALT_CAP;
      S_HALT_CAP:  next_state = S_IDLE;
      default:     next_state = S_FETCH_1;              // End of AND, TAD, ISZ, DCA, JMP
    endcase
  end

  always_comb begin
    ctrl.ac_op       = AC_NC;
    ctrl.pc_op       = PC_NC;
    ctrl.ea_op       = EA_NC;
    ctrl.mb_op       = MB_NC;
    ctrl.ir_load     = 1'b0;
    ctrl.addr_sel    = AD_PC;
    ctrl.wdata_sel   = WD_AC;
    mem.read_enable  = 1'b0;
    mem.write_enable = 1'b0;
    panel.cmd_ready  = 1'b0;
    report_capture   = 1'b0;
    case (state)
      S_IDLE:  panel.cmd_ready = 1'b1;
      S_LD_PC: ctrl.pc_op = PC_SR;
      S_DEP_1: ctrl.wdata_sel = WD_SR;
      S_DEP_2: begin
        ctrl.wdata_sel   = WD_SR;
        mem.write_enable = 1'b1;
        if (mem.finished)
          ctrl.pc_op = PC_P1;
      end
      S_FETCH_2: mem.read_enable = 1'b1;
      S_FETCH_3: ctrl.ir_load = 1'b1;
      S_DECODE: begin
        if (is_halt || is_dropped)
          ctrl.pc_op = PC_P1;
        else
          ctrl.ea_op = ctrl.ir[7] ? EA_CURR_PAGE : EA_PAGE_ZERO;
      end
      S_IND_1, S_AND_1, S_TAD_1, S_ISZ_1: ctrl.addr_sel = AD_EA;
      S_IND_2, S_AND_2, S_TAD_2, S_ISZ_2: begin
        ctrl.addr_sel   = AD_EA;
        mem.read_enable = 1'b1;
        if (mem.finished)
          ctrl.mb_op = MB_RD;
      end
      S_IND_3: ctrl.ea_op = EA_INDIRECT;
      S_AND_3: begin
        ctrl.ac_op = AC_AND;
        ctrl.pc_op = PC_P1;
      end
      S_TAD_3: begin
        ctrl.ac_op = AC_TAD;
        ctrl.pc_op = PC_P1;
      end
      S_ISZ_3: ctrl.mb_op = MB_INC;
      S_ISZ_4: begin
        ctrl.addr_sel  = AD_EA;
        ctrl.wdata_sel = WD_MB;
      end
      S_ISZ_5: begin
        ctrl.addr_sel    = AD_EA;
        ctrl.wdata_sel   = WD_MB;
        mem.write_enable = 1'b1;
      end
      S_ISZ_6: ctrl.pc_op = (ctrl.mb == '0) ? PC_P2 : PC_P1;   // Skip on wrap to zero
      S_DCA_1: ctrl.addr_sel = AD_EA;
      S_DCA_2: begin
        ctrl.addr_sel    = AD_EA;
        mem.write_enable = 1'b1;
        if (mem.finished)
          ctrl.mb_op = MB_WD;
      end
      S_DCA_3: begin
        ctrl.ac_op = AC_CLEAR;
        ctrl.pc_op = PC_P1;
      end
      S_JMP_1:    ctrl.pc_op = PC_JMP;
      S_HALT_CAP: report_capture = 1'b1;
      default: ;
    endcase
  end

  a_one_enable: assert property (@(posedge clock) disable iff (!resetN)
    !(mem.read_enable && mem.write_enable))
    else $error("Memory read and write requested together");

endmodule

`default_nettype wire

// ==== src/cpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU datapath: AC, link, PC, IR, EA and MB registers with
// memory address and write data selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cpu_datapath (
  input  logic            clock,
  input  logic            resetN,
  cpu_ctrl_if.datapath    ctrl,
  mem_if.datapath         mem,
  panel_if.datapath       panel,
  output pdp8_pkg::word_t pc,
  output pdp8_pkg::word_t ac,
  output logic            link
);
  import pdp8_pkg::*;

  word_t       ir;
  word_t       ea;
  word_t       mb;
  logic [12:0] tad_sum;

  assign tad_sum = {1'b0, ac} + {1'b0, mb};             // Bit 12 is the carry out

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
      pc   <= '0;
      ir   <= '0;
    end else begin
      case (ctrl.ac_op)
        AC_AND: ac <= ac & mb;
        AC_TAD: begin
          ac   <= tad_sum[11:0];
          link <= link ^ tad_sum[12];                   // Carry complements link
        end
        AC_CLEAR: ac <= '0;
        default: ;
      endcase

      case (ctrl.pc_op)
        PC_P1:  pc <= pc + 12'd1;
        PC_P2:  pc <= pc + 12'd2;
        PC_JMP: pc <= ea;
        PC_SR:  pc <= panel.switch_word;
        default: ;
      endcase

      if (ctrl.ir_load)
        ir <= mem.rdata;
    end
  end

  always_ff @(posedge clock) begin
    case (ctrl.ea_op)
      EA_PAGE_ZERO: ea <= {5'b0, ir[6:0]};
      EA_CURR_PAGE: ea <= {pc[11:7], ir[6:0]};
      EA_INDIRECT:  ea <= mb;                           // Pointer word from memory
      default: ;
    endcase

    case (ctrl.mb_op)
      MB_RD:  mb <= mem.rdata;
      MB_INC: mb <= mb + 12'd1;
      MB_WD:  mb <= mem.wdata;
      default: ;
    endcase
  end

  always_comb begin
    mem.addr = (ctrl.addr_sel == AD_EA) ? ea : pc;
    case (ctrl.wdata_sel)
      WD_SR:   mem.wdata = panel.switch_word;
      WD_MB:   mem.wdata = mb;
      default: mem.wdata = ac;
    endcase
  end

  assign ctrl.ir = ir;
  assign ctrl.mb = mb;

endmodule

`default_nettype wire

// ==== src/panel_intake.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Panel intake: one-entry command register for the controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module panel_intake (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  pdp8_pkg::panel_cmd_t cmd_op,
  input  pdp8_pkg::word_t      switch_word,
  panel_if.intake              panel
);
  import pdp8_pkg::*;

  word_t held_word;
  logic  accept;
  logic  taken;

  assign cmd_ready = !panel.cmd_valid;                  // Empty slot
  assign accept    = cmd_valid && cmd_ready;
  assign taken     = panel.cmd_valid && panel.cmd_ready;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      panel.cmd_valid <= 1'b0;
    end else if (accept) begin
      panel.cmd_valid <= 1'b1;
    end else if (taken) begin
      panel.cmd_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      panel.cmd_op <= cmd_op;
      held_word    <= switch_word;
    end
    if (taken)
      panel.switch_word <= held_word;                   // Word of the command in progress
  end

  a_held_stable: assert property (@(posedge clock) disable iff (!resetN)
    panel.cmd_valid && !panel.cmd_ready |=>
      panel.cmd_valid && $stable(panel.cmd_op) && $stable(held_word))
    else $error("Held panel command changed before the controller took it");

endmodule

`default_nettype wire

// ==== src/pdp8_core.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDP-8 core top: panel intake, CPU, core memory and report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pdp8_core #(
  parameter int MEM_WAIT_CYCLES = 2
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  pdp8_pkg::panel_cmd_t cmd_op,
  input  pdp8_pkg::word_t      switch_word,
  output logic                 done_valid,
  input  logic                 done_ready,
  output pdp8_pkg::word_t      done_pc,
  output pdp8_pkg::word_t      done_ac,
  output logic                 done_link
);
  import pdp8_pkg::*;

  word_t pc;
  word_t ac;
  logic  link;
  logic  report_busy;
  logic  report_capture;

  panel_if    panel ();
  cpu_ctrl_if ctrl ();
  mem_if      mem ();

  panel_intake i_panel_intake (
    .clock, .resetN,
    .cmd_valid, .cmd_ready, .cmd_op, .switch_word,
    .panel (panel)
  );

  cpu_controller i_cpu_controller (
    .clock, .resetN,
    .panel (panel), .ctrl (ctrl), .mem (mem),
    .report_busy, .report_capture
  );

  cpu_datapath i_cpu_datapath (
    .clock, .resetN,
    .ctrl (ctrl), .mem (mem), .panel (panel),
    .pc, .ac, .link
  );

  core_memory #(.MEM_WAIT_CYCLES(MEM_WAIT_CYCLES)) i_core_memory (
    .clock, .resetN,
    .mem (mem)
  );

  run_report i_run_report (
    .clock, .resetN,
    .report_capture, .pc, .ac, .link, .report_busy,
    .done_valid, .done_ready, .done_pc, .done_ac, .done_link
  );

endmodule

`default_nettype wire

// ==== src/pdp8_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal buses: panel command, controller/datapath, memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface panel_if;
  import pdp8_pkg::*;

  logic       cmd_valid;
  logic       cmd_ready;
  panel_cmd_t cmd_op;
  word_t      switch_word;

  modport intake     (output cmd_valid, cmd_op, switch_word, input cmd_ready);
  modport controller (input cmd_valid, cmd_op, output cmd_ready);
  modport datapath   (input switch_word);
endinterface

interface cpu_ctrl_if;
  import pdp8_pkg::*;

  ac_op_t     ac_op;
  pc_op_t     pc_op;
  ea_op_t     ea_op;
  mb_op_t     mb_op;
  logic       ir_load;
  addr_sel_t  addr_sel;
  wdata_sel_t wdata_sel;
  word_t      ir;
  word_t      mb;

  modport controller (output ac_op, pc_op, ea_op, mb_op, ir_load, addr_sel, wdata_sel,
                      input  ir, mb);
  modport datapath   (input  ac_op, pc_op, ea_op, mb_op, ir_load, addr_sel, wdata_sel,
                      output ir, mb);
endinterface

interface mem_if;
  import pdp8_pkg::*;

  word_t addr;
  word_t wdata;
  word_t rdata;
  logic  read_enable;
  logic  write_enable;
  logic  finished;

  modport controller (output read_enable, write_enable, input finished);
  modport datapath   (output addr, wdata, input rdata);
  modport memory     (input addr, wdata, read_enable, write_enable, output rdata, finished);
endinterface

`default_nettype wire

// ==== src/pdp8_pkg.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDP-8 shared types: machine word, opcodes, panel commands
// and the datapath control encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pdp8_pkg;

  typedef logic [11:0] word_t;

  typedef enum logic [2:0] {
    OP_AND = 3'o0,
    OP_TAD = 3'o1,
    OP_ISZ = 3'o2,
    OP_DCA = 3'o3,
    OP_JMS = 3'o4,
    OP_JMP = 3'o5,
    OP_IOT = 3'o6,
    OP_OPR = 3'o7
  } opcode_t;

  typedef enum logic [1:0] {
    CMD_LOAD_PC,
    CMD_DEPOSIT,
    CMD_RUN
  } panel_cmd_t;

  typedef enum logic [1:0] {AC_NC, AC_AND, AC_TAD, AC_CLEAR} ac_op_t;   // AC and link

  typedef enum logic [2:0] {PC_NC, PC_P1, PC_P2, PC_JMP, PC_SR} pc_op_t;

  typedef enum logic [1:0] {EA_NC, EA_PAGE_ZERO, EA_CURR_PAGE, EA_INDIRECT} ea_op_t;

  typedef enum logic [1:0] {MB_NC, MB_RD, MB_INC, MB_WD} mb_op_t;

  typedef enum logic {AD_PC, AD_EA} addr_sel_t;

  typedef enum logic [1:0] {WD_SR, WD_AC, WD_MB} wdata_sel_t;

  localparam word_t HALT_WORD = 12'o7402;   // Group 2 HLT
  localparam int    MEM_WORDS = 4096;

endpackage

`default_nettype wire

// ==== src/run_report.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Run report: holds PC, AC and link at halt until accepted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module run_report (
  input  logic            clock,
  input  logic            resetN,
  input  logic            report_capture,
  input  pdp8_pkg::word_t pc,
  input  pdp8_pkg::word_t ac,
  input  logic            link,
  output logic            report_busy,
  output logic            done_valid,
  input  logic            done_ready,
  output pdp8_pkg::word_t done_pc,
  output pdp8_pkg::word_t done_ac,
  output logic            done_link
);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      done_valid <= 1'b0;
    else if (report_capture)
      done_valid <= 1'b1;
    else if (done_ready)
      done_valid <= 1'b0;                               // Report accepted
  end

  always_ff @(posedge clock) begin
    if (report_capture) begin
      done_pc   <= pc;
      done_ac   <= ac;
      done_link <= link;
    end
  end

  assign report_busy = done_valid;

  a_no_overwrite: assert property (@(posedge clock) disable iff (!resetN)
    report_capture |-> !report_busy)
    else $error("Halt report captured over a pending report");

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock (20 ns) and active-low reset for 4 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen (
  output logic clock,
  output logic resetN
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    resetN = 1'b0;
    repeat (4) @(posedge clock);
    resetN <= 1'b1;                                     // Released on the 4th rising edge
  end

endmodule

`default_nettype wire

// ==== verification/tb_pdp8_core.sv ====
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PDP-8 core testbench: panel commands, programs run to HALT
// and checks of the halt report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_pdp8_core;
  import pdp8_pkg::*;

  localparam int READY_TIMEOUT  = 200;
  localparam int REPORT_TIMEOUT = 3000;
  localparam int HOLD_CYCLES    = 40;

  logic       clock;
  logic       resetN;
  logic       cmd_valid;
  logic       cmd_ready;
  panel_cmd_t cmd_op;
  word_t      switch_word;
  logic       done_valid;
  logic       done_ready;
  word_t      done_pc;
  word_t      done_ac;
  logic       done_link;

  int     error_count;
  int     check_count;
  int     test_count;
  int     failed_tests;
  int     test_start_errors;
  integer seed;
  word_t  model_ac;                                     // Expected AC, kept across runs
  logic   model_link;
  word_t  program_words[$];
  word_t  report_pc;
  word_t  report_ac;
  logic   report_link;

  tb_clock_gen i_clock_gen (.clock, .resetN);

  pdp8_core #(.MEM_WAIT_CYCLES(2)) i_pdp8_core (
    .clock, .resetN, .cmd_valid, .cmd_ready, .cmd_op, .switch_word,
    .done_valid, .done_ready, .done_pc, .done_ac, .done_link
  );

  // Memory reference word: opcode, indirect, current page, page offset
  function automatic word_t encode_mri(opcode_t op, logic indirect, logic curr_page,
                                       logic [6:0] offset);
    return {op, indirect, curr_page, offset};
  endfunction

  // TAD wraps at 12 bits and a carry out complements the link
  function automatic void apply_tad(word_t operand);
    int total;
    total = int'(model_ac) + int'(operand);
    if (total > 12'o7777)
      model_link = !model_link;
    model_ac = word_t'(total);
  endfunction

  task automatic compare_word(string test, string what, word_t expected, word_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s %s: expected %04o actual %04o", test, what, expected, actual);
    end
  endtask

  task automatic compare_bit(string test, string what, logic expected, logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s %s: expected %b actual %b", test, what, expected, actual);
    end
  endtask

  task automatic begin_test();
    test_start_errors = error_count;
    test_count++;
  endtask

  task automatic end_test(string test);
    if (error_count == test_start_errors) begin
      $display("%s: PASS", test);
    end else begin
      failed_tests++;
      $display("%s: FAIL (%0d errors)", test, error_count - test_start_errors);
    end
  endtask

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (resetN !== 1'b1 && cycles < READY_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (resetN !== 1'b1) begin
      error_count++;
      $display("TIMEOUT: reset was never released");
    end
  endtask

  task automatic wait_ready(string test);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!cmd_ready && cycles < READY_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!cmd_ready) begin
      error_count++;
      $display("TIMEOUT %s: cmd_ready stayed low for %0d cycles", test, READY_TIMEOUT);
    end
  endtask

  task automatic send_command(string test, panel_cmd_t op, word_t word);
    @(posedge clock);
    cmd_valid   <= 1'b1;
    cmd_op      <= op;
    switch_word <= word;
    wait_ready(test);
    @(posedge clock);                                   // Transfer edge
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_report(string test);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!done_valid && cycles < REPORT_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (!done_valid) begin
      error_count++;
      $display("TIMEOUT %s: no halt report within %0d cycles", test, REPORT_TIMEOUT);
    end
    report_pc   = done_pc;
    report_ac   = done_ac;
    report_link = done_link;
  endtask

  task automatic accept_report();
    @(posedge clock);
    done_ready <= 1'b1;
    @(posedge clock);
    done_ready <= 1'b0;
  endtask

  task automatic load_program(string test, word_t start);
    send_command(test, CMD_LOAD_PC, start);
    foreach (program_words[i])
      send_command(test, CMD_DEPOSIT, program_words[i]);
    program_words.delete();
  endtask

  task automatic deposit_word(string test, word_t addr, word_t word);
    send_command(test, CMD_LOAD_PC, addr);
    send_command(test, CMD_DEPOSIT, word);
  endtask

  task automatic run_program(string test, word_t start);
    send_command(test, CMD_LOAD_PC, start);
    send_command(test, CMD_RUN, '0);
    wait_report(test);
    accept_report();
  endtask

  task automatic check_report(string test, word_t expected_pc);
    compare_word(test, "done_pc", expected_pc, report_pc);
    compare_word(test, "done_ac", model_ac, report_ac);
    compare_bit(test, "done_link", model_link, report_link);
  endtask

  task automatic test_reset_halt();
    begin_test();
    @(negedge clock);
    compare_bit("reset_halt", "cmd_ready", 1'b1, cmd_ready);
    compare_bit("reset_halt", "done_valid", 1'b0, done_valid);
    send_command("reset_halt", CMD_DEPOSIT, HALT_WORD);  // PC is 0 out of reset
    run_program("reset_halt", 12'o0000);
    check_report("reset_halt", 12'o0001);
    end_test("reset_halt");
  endtask

  task automatic test_jmp();
    begin_test();
    deposit_word("jmp", 12'o0210, HALT_WORD);
    program_words.push_back(encode_mri(OP_JMP, 1'b0, 1'b1, 7'o010));
    load_program("jmp", 12'o0200);
    run_program("jmp", 12'o0200);
    check_report("jmp", 12'o0211);
    end_test("jmp");
  endtask

  // Operands at 0040..0042, result at 0043, program at 0400
  task automatic run_arith(string test, word_t a, word_t b, word_t mask);
    word_t stored;
    program_words.push_back(a);
    program_words.push_back(b);
    program_words.push_back(mask);
    load_program(test, 12'o0040);
    program_words.push_back(encode_mri(OP_DCA, 1'b0, 1'b0, 7'o044));   // Clears AC
    program_words.push_back(encode_mri(OP_TAD, 1'b0, 1'b0, 7'o040));
    program_words.push_back(encode_mri(OP_TAD, 1'b0, 1'b0, 7'o041));
    program_words.push_back(encode_mri(OP_AND, 1'b0, 1'b0, 7'o042));
    program_words.push_back(encode_mri(OP_DCA, 1'b0, 1'b0, 7'o043));
    program_words.push_back(encode_mri(OP_TAD, 1'b0, 1'b0, 7'o043));   // Readback
    program_words.push_back(HALT_WORD);
    load_program(test, 12'o0400);
    run_program(test, 12'o0400);
    model_ac = '0;
    apply_tad(a);
    apply_tad(b);
    model_ac = model_ac & mask;
    stored   = model_ac;
    model_ac = '0;
    apply_tad(stored);
    check_report(test, 12'o0407);
  endtask

  task automatic test_tad_and_dca();
    begin_test();
    run_arith("tad_and_dca", 12'o6543, 12'o3456, 12'o7070);   // Sum carries out
    end_test("tad_and_dca");
  endtask

  task automatic test_isz_indirect();
    word_t counter;
    begin_test();
    program_words.push_back(12'o7777);                  // Counter at 0050
    program_words.push_back(12'o0652);                  // Pointer at 0051
    load_program("isz_indirect", 12'o0050);
    deposit_word("isz_indirect", 12'o0652, 12'o1234);
    program_words.push_back(encode_mri(OP_DCA, 1'b0, 1'b0, 7'o052));
    program_words.push_back(encode_mri(OP_ISZ, 1'b0, 1'b0, 7'o050));
    program_words.push_back(HALT_WORD);                 // Skipped when the counter wraps
    program_words.push_back(encode_mri(OP_TAD, 1'b1, 1'b0, 7'o051));
    program_words.push_back(encode_mri(OP_ISZ, 1'b0, 1'b0, 7'o050));
    program_words.push_back(encode_mri(OP_TAD, 1'b0, 1'b0, 7'o050));
    program_words.push_back(HALT_WORD);
    load_program("isz_indirect", 12'o0600);
    run_program("isz_indirect", 12'o0600);
    model_ac = '0;
    counter  = 12'o7777 + 12'o0001;                     // Wraps to zero, first HALT skipped
    apply_tad(12'o1234);
    counter = counter + 12'o0001;
    apply_tad(counter);
    check_report("isz_indirect", 12'o0607);
    end_test("isz_indirect");
  endtask

  task automatic test_back_pressure();
    word_t first_pc;
    word_t first_ac;
    logic  first_link;
    int    hold_errors;
    begin_test();
    hold_errors = 0;
    deposit_word("back_pressure", 12'o0700, HALT_WORD);
    send_command("back_pressure", CMD_LOAD_PC, 12'o0000);
    send_command("back_pressure", CMD_RUN, '0);
    wait_report("back_pressure");
    first_pc   = report_pc;
    first_ac   = report_ac;
    first_link = report_link;
    check_report("back_pressure", 12'o0001);
    send_command("back_pressure", CMD_LOAD_PC, 12'o0700);
    send_command("back_pressure", CMD_RUN, '0);
    send_command("back_pressure", CMD_LOAD_PC, 12'o0000);   // Stays in the intake
    repeat (HOLD_CYCLES) begin
      @(negedge clock);
      if (!done_valid || done_pc !== first_pc || done_ac !== first_ac ||
          done_link !== first_link || cmd_ready)
        hold_errors++;
    end
    check_count++;
    if (hold_errors != 0) begin
      error_count++;
      $display("ERROR back_pressure: first report changed or cmd_ready rose in %0d cycles",
               hold_errors);
    end
    accept_report();
    wait_report("back_pressure");
    check_report("back_pressure", 12'o0701);
    accept_report();
    wait_ready("back_pressure");                        // Held command drains
    end_test("back_pressure");
  endtask

  task automatic test_random_arith();
    word_t a;
    word_t b;
    word_t mask;
    begin_test();
    repeat (8) begin
      a    = word_t'($random(seed));
      b    = word_t'($random(seed));
      mask = word_t'($random(seed));
      run_arith("random_arith", a, b, mask);
    end
    end_test("random_arith");
  endtask

  initial begin
    cmd_valid    = 1'b0;
    cmd_op       = CMD_LOAD_PC;
    switch_word  = '0;
    done_ready   = 1'b0;
    error_count  = 0;
    check_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    seed         = 29837;
    model_ac     = '0;
    model_link   = 1'b0;
    wait_for_reset();
    test_reset_halt();
    test_jmp();
    test_tad_and_dca();
    test_isz_indirect();
    test_back_pressure();
    test_random_arith();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
